// ==== media_loader_top.f ====
hw/media_pkg.sv
hw/media_config.sv
hw/cart_loader.sv
hw/bios_rom.sv
hw/backup_manager.sv
hw/media_loader_top.sv
testbench/tb_media_loader.sv

// ==== testbench/tb_media_loader.sv ====
//============================================================
// testbench for the media loading top level
// bios download and patched readback, cart download into an
// external memory model, then backup load, save and autosave
// through an sd sector model. concurrent assertions check
//============================================================
`timescale 1ns/1ps

module tb_media_loader;
	import media_pkg::*;

	// ========================================================
	// run length and timeout
	// ========================================================
	localparam int SECTOR_CYC = 256 + 8;                 // stream + ack delay + edges
	localparam int XFER_CYC   = BK_SECTORS * SECTOR_CYC;
	// load, save, autosave + loaders, rounded up to the next thousand
	localparam int TIMEOUT    = ((3 * XFER_CYC + 400) / 1000 + 1) * 1000;
	localparam logic [BIOS_ADDR_W-1:0] BIOS_BASE = 17'h01368; // 16 bytes around the patch

	logic                        clk_sys, reset;
	logic                        dl_active, dl_wr, dl_wait;
	dl_index_e                   dl_index;
	logic [DL_ADDR_W-1:0]        dl_addr;
	logic [15:0]                 dl_data;
	logic                        cfg_wr;
	cfg_reg_e                    cfg_sel;
	logic [7:0]                  cfg_data;
	logic [MEM_ADDR_W-1:0]       mem_addr;
	logic [63:0]                 mem_din;
	logic [7:0]                  mem_be;
	logic                        mem_we, mem_ack;
	logic [BIOS_ADDR_W-1:0]      bios_addr;
	logic [7:0]                  bios_q;
	logic [BRAM_ADDR_W-1:0]      bram_addr;
	logic [15:0]                 bram_data, bram_q;
	logic                        bram_wr;
	logic [1:0]                  sd_lba;
	logic                        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [7:0]                  sd_buff_addr;
	logic [15:0]                 sd_buff_dout, sd_buff_din;
	logic                        osd_status, led_user, core_reset_n;

	// reference models and check strobes
	logic [31:0]           lfsr = 32'hf294;
	logic [7:0]            bios_img [0:15];
	logic [15:0]           sd_img [0:1023];      // four sector card image
	logic [15:0]           bram_img [0:1023];    // expected save ram
	logic [MEM_ADDR_W-1:0] exp_addr;
	logic [7:0]            exp_be, bios_exp, bios_exp_q;
	logic [63:0]           exp_din;
	logic [15:0]           bram_exp, bram_exp_q, save_exp, save_exp_q;
	logic                  bios_rd, bram_rd, save_chk, idle_chk, pend_chk, exp_save;
	logic [1:0]            next_lba;
	int                    errors = 0;
	int                    cycles = 0;
	int                    sectors_done = 0;

	media_loader_top u_media_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;    // 125 MHz
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int b;
		v = '0;
		for (b = 0; b < n; b++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// count a failed check and print its line
	function automatic void log_error(input string msg);
		errors++;
		$display("%s", msg);
	endfunction

	always @(posedge clk_sys) begin
		bios_exp_q <= bios_exp;   // expected data lines up with 1-cycle reads
		bram_exp_q <= bram_exp;
		save_exp_q <= save_exp;
	end

	// ========================================================
	// assertions
	// ========================================================
	assert property (@(posedge clk_sys)
		$fell(reset) |-> !(dl_wait || mem_we || sd_rd || sd_wr || led_user))
		else log_error($sformatf(
			"[ERROR] outputs after reset dl_wait/mem_we/sd_rd/sd_wr/led_user %h/%h/%h/%h/%h",
			$sampled(dl_wait), $sampled(mem_we), $sampled(sd_rd), $sampled(sd_wr),
			$sampled(led_user)));
	assert property (@(posedge clk_sys) (reset || dl_active) == !core_reset_n)
		else log_error($sformatf("[ERROR] core_reset_n %h with reset %h dl_active %h",
			$sampled(core_reset_n), $sampled(reset), $sampled(dl_active)));
	assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr && dl_active && dl_index == IDX_CART |=> mem_we)
		else log_error($sformatf("[ERROR] mem_we got %h expected 1 after dl_wr",
			$sampled(mem_we)));
	assert property (@(posedge clk_sys) disable iff (reset) mem_we |-> mem_addr == exp_addr)
		else log_error($sformatf("[ERROR] mem_addr got %h expected %h",
			$sampled(mem_addr), exp_addr));
	assert property (@(posedge clk_sys) disable iff (reset) mem_we |-> mem_be == exp_be)
		else log_error($sformatf("[ERROR] mem_be got %h expected %h",
			$sampled(mem_be), exp_be));
	assert property (@(posedge clk_sys) disable iff (reset) mem_we |-> mem_din == exp_din)
		else log_error($sformatf("[ERROR] mem_din got %h expected %h",
			$sampled(mem_din), exp_din));
	assert property (@(posedge clk_sys) disable iff (reset) mem_we |-> dl_wait ##1 !mem_we)
		else log_error($sformatf("[ERROR] mem_we/dl_wait strobe %h/%h",
			$sampled(mem_we), $sampled(dl_wait)));
	assert property (@(posedge clk_sys) disable iff (reset) dl_wait && !mem_ack |=> dl_wait)
		else log_error($sformatf("[ERROR] dl_wait got %h expected 1 before mem_ack",
			$sampled(dl_wait)));
	assert property (@(posedge clk_sys) disable iff (reset) mem_ack |=> !dl_wait)
		else log_error($sformatf("[ERROR] dl_wait got %h expected 0 after mem_ack",
			$sampled(dl_wait)));
	assert property (@(posedge clk_sys) disable iff (reset)
		dl_active && dl_index != IDX_CART |-> !dl_wait)
		else log_error($sformatf("[ERROR] dl_wait got %h during bios download",
			$sampled(dl_wait)));
	assert property (@(posedge clk_sys) disable iff (reset) bios_rd |=> bios_q == bios_exp_q)
		else log_error($sformatf("[ERROR] bios_q got %h expected %h",
			$sampled(bios_q), $sampled(bios_exp_q)));
	assert property (@(posedge clk_sys) disable iff (reset) bram_rd |=> bram_q == bram_exp_q)
		else log_error($sformatf("[ERROR] bram_q got %h expected %h",
			$sampled(bram_q), $sampled(bram_exp_q)));
	assert property (@(posedge clk_sys) disable iff (reset)
		save_chk |=> sd_buff_din == save_exp_q)
		else log_error($sformatf("[ERROR] sd_buff_din got %h expected %h",
			$sampled(sd_buff_din), $sampled(save_exp_q)));
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd || sd_wr) |-> sd_lba == next_lba && sd_wr == exp_save)
		else log_error($sformatf("[ERROR] sd_lba/sd_wr got %h/%h expected %h/%h",
			$sampled(sd_lba), $sampled(sd_wr), next_lba, exp_save));
	assert property (@(posedge clk_sys) disable iff (reset) $rose(sd_ack) |=> !(sd_rd || sd_wr))
		else log_error($sformatf("[ERROR] sd_rd/sd_wr got %h/%h expected 0/0 after sd_ack",
			$sampled(sd_rd), $sampled(sd_wr)));
	assert property (@(posedge clk_sys) disable iff (reset) idle_chk |-> !led_user)
		else log_error($sformatf("[ERROR] led_user got %h expected 0 after transfer",
			$sampled(led_user)));
	assert property (@(posedge clk_sys) disable iff (reset) pend_chk |-> led_user)
		else log_error($sformatf("[ERROR] led_user got %h expected 1 with unsaved writes",
			$sampled(led_user)));

	// ========================================================
	// memory and sd models
	// ========================================================
	initial begin : mem_model
		int d;
		forever begin
			@(negedge clk_sys);
			if (mem_we) begin
				d = 1 + int'(rand_bits(2));   // 1..4 cycles
				repeat (d - 1) @(negedge clk_sys);
				mem_ack = 1'b1;
				@(negedge clk_sys);
				mem_ack = 1'b0;
			end
		end
	end

	task automatic serve_sector();
		int k, base, d;
		logic load;
		base = int'(sd_lba) * 256;
		load = sd_rd;
		d = 1 + int'(rand_bits(2));
		repeat (d) @(negedge clk_sys);
		sd_ack = 1'b1;
		for (k = 0; k < 256; k++) begin
			sd_buff_addr = 8'(k);
			sd_buff_wr   = load;             // loads write the save ram
			sd_buff_dout = sd_img[base + k];
			if (load)
				bram_img[base + k] = sd_img[base + k];
			save_chk = !load;                // saves read it back
			save_exp = bram_img[base + k];
			@(negedge clk_sys);
		end
		sd_buff_wr = 1'b0;
		save_chk   = 1'b0;
		sd_ack     = 1'b0;
		next_lba   = 2'(base / 256 + 1);
		sectors_done++;
	endtask

	initial begin : sd_model
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr)
				serve_sector();
		end
	end

	// ========================================================
	// stimulus tasks
	// ========================================================
	task automatic cfg_write(input cfg_reg_e sel, input logic [7:0] data);
		cfg_sel  = sel;
		cfg_data = data;
		cfg_wr   = 1'b1;
		@(negedge clk_sys);
		cfg_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic bios_download();
		int k;
		logic [15:0] w;
		dl_index  = IDX_BIOS;
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (k = 0; k < 8; k++) begin
			w = 16'(rand_bits(16));
			bios_img[2*k]   = w[7:0];          // low byte at the even address
			bios_img[2*k+1] = w[15:8];
			dl_addr = DL_ADDR_W'(BIOS_BASE + 17'(2*k));
			dl_data = w;
			dl_wr   = 1'b1;
			@(negedge clk_sys);
			dl_wr = 1'b0;
			@(negedge clk_sys);
		end
		repeat (2) @(negedge clk_sys);       // let the last high byte land
		dl_active = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic read_bios(input logic patched);
		int k;
		for (k = 0; k < 16; k++) begin
			bios_addr = BIOS_BASE + 17'(k);
			bios_exp  = (patched && bios_addr == BIOS_PATCH_ADDR) ?
				BIOS_PATCH_BYTE : bios_img[k];
			bios_rd   = 1'b1;
			@(negedge clk_sys);
		end
		bios_rd = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic cart_download(input int n);
		int k;
		logic [23:0] byte_addr;
		dl_index  = IDX_CART;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (k = 0; k < n; k++) begin
			while (dl_wait)
				@(negedge clk_sys);
			byte_addr = CART_BASE + 24'(2*k);
			dl_addr   = DL_ADDR_W'(2*k);
			dl_data   = 16'(rand_bits(16));
			exp_addr  = {MEM_REGION, byte_addr[23:3]};
			exp_be    = 8'hC0 >> {byte_addr[2:1], 1'b0};  // C0 30 0C 03
			exp_din   = {4{dl_data[7:0], dl_data[15:8]}};
			dl_wr     = 1'b1;
			@(negedge clk_sys);
			dl_wr = 1'b0;
			@(negedge clk_sys);
		end
		while (dl_wait)
			@(negedge clk_sys);
		dl_active = 1'b0;                    // end of cart starts the backup load
	endtask

	task automatic read_bram();
		int k;
		for (k = 0; k < 64; k++) begin
			bram_addr = BRAM_ADDR_W'(k*16 + k%16);  // spread over all sectors
			bram_exp  = bram_img[bram_addr];
			bram_rd   = 1'b1;
			@(negedge clk_sys);
		end
		bram_rd = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic write_bram(input int n);
		int k;
		for (k = 0; k < n; k++) begin
			bram_addr = BRAM_ADDR_W'(rand_bits(BRAM_ADDR_W));
			bram_data = 16'(rand_bits(16));
			bram_img[bram_addr] = bram_data;
			bram_wr = 1'b1;
			@(negedge clk_sys);
		end
		bram_wr  = 1'b0;
		pend_chk = 1'b1;                     // unsaved flag now lights the led
		@(negedge clk_sys);
		pend_chk = 1'b0;
	endtask

	task automatic wait_sectors(input int target);
		while (sectors_done < target)
			@(negedge clk_sys);
		@(negedge clk_sys);
		idle_chk = 1'b1;
		@(negedge clk_sys);
		idle_chk = 1'b0;
	endtask

	// ========================================================
	// test sequence
	// ========================================================
	initial begin : stimulus
		int i;
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_index     = IDX_BIOS;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cfg_wr       = 1'b0;
		cfg_sel      = CFG_OPTIONS;
		cfg_data     = '0;
		mem_ack      = 1'b0;
		bios_addr    = '0;
		bram_addr    = '0;
		bram_data    = '0;
		bram_wr      = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		osd_status   = 1'b0;
		bios_rd      = 1'b0;
		bram_rd      = 1'b0;
		save_chk     = 1'b0;
		idle_chk     = 1'b0;
		pend_chk     = 1'b0;
		exp_save     = 1'b0;
		next_lba     = '0;
		bios_exp     = '0;
		bram_exp     = '0;
		save_exp     = '0;
		exp_addr     = '0;
		exp_be       = '0;
		exp_din      = '0;
		for (i = 0; i < 1024; i++) begin
			sd_img[i]   = 16'(i * 37) ^ 16'hA5C3;  // unique per word address
			bram_img[i] = '0;
		end
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		repeat (2) @(negedge clk_sys);

		bios_download();
		read_bios(1'b0);
		cfg_write(CFG_OPTIONS, 8'h01);       // patch on
		read_bios(1'b1);

		cart_download(16);
		wait_sectors(4);                     // automatic load
		read_bram();

		write_bram(8);
		exp_save = 1'b1;
		cfg_write(CFG_COMMAND, 8'h02);       // save command
		wait_sectors(8);

		cfg_write(CFG_OPTIONS, 8'h03);       // patch + autosave
		write_bram(4);
		osd_status = 1'b1;                   // menu opens, autosave kicks in
		wait_sectors(12);
		osd_status = 1'b0;
		repeat (3) @(negedge clk_sys);

		$display("end of test: %0d errors, %0d sectors moved, %0d cycles",
			errors, sectors_done, cycles);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: test did not end within %0d cycles, %0d errors", TIMEOUT, errors);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

// ==== hw/media_loader_top.sv ====
//============================================================
// media loading top level
// options block steering the cart loader, the bios rom and
// the backup ram manager. core reset held during downloads
//============================================================
`timescale 1ns/1ps

module media_loader_top (
	input  logic                                        clk_sys,
	input  logic                                        reset,
	// host download
	input  logic                                        dl_active,
	input  media_pkg::dl_index_e                        dl_index,
	input  logic                                        dl_wr,
	input  logic [media_pkg::DL_ADDR_W-1:0]             dl_addr,
	input  logic [15:0]                                 dl_data,
	output logic                                        dl_wait,
	// options
	input  logic                                        cfg_wr,
	input  media_pkg::cfg_reg_e                         cfg_sel,
	input  logic [7:0]                                  cfg_data,
	// external memory
	output logic [media_pkg::MEM_ADDR_W-1:0]            mem_addr,
	output logic [63:0]                                 mem_din,
	output logic [7:0]                                  mem_be,
	output logic                                        mem_we,
	input  logic                                        mem_ack,
	// core side
	input  logic [media_pkg::BIOS_ADDR_W-1:0]           bios_addr,
	output logic [7:0]                                  bios_q,
	input  logic [media_pkg::BRAM_ADDR_W-1:0]           bram_addr,
	input  logic [15:0]                                 bram_data,
	input  logic                                        bram_wr,
	output logic [15:0]                                 bram_q,
	// sd sector buffer
	output logic [$clog2(media_pkg::BK_SECTORS)-1:0]    sd_lba,
	output logic                                        sd_rd,
	output logic                                        sd_wr,
	input  logic                                        sd_ack,
	input  logic [7:0]                                  sd_buff_addr,
	input  logic [15:0]                                 sd_buff_dout,
	input  logic                                        sd_buff_wr,
	output logic [15:0]                                 sd_buff_din,
	// misc
	input  logic                                        osd_status,
	output logic                                        led_user,
	output logic                                        core_reset_n
);
	import media_pkg::*;

	logic patch_en, autosave, bk_load_cmd, bk_save_cmd;
	logic cart_busy, bk_busy, bk_pending;

	assign led_user     = dl_active || bk_busy || bk_pending;
	assign core_reset_n = !(reset || dl_active);   // core held through any download

	media_config u_media_config (
		.clk_sys, .reset, .cfg_wr, .cfg_sel, .cfg_data,
		.patch_en, .autosave, .bk_load_cmd, .bk_save_cmd
	);

	cart_loader u_cart_loader (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_wr, .dl_addr, .dl_data,
		.mem_addr, .mem_din, .mem_be, .mem_we, .mem_ack, .dl_wait, .cart_busy
	);

	bios_rom u_bios_rom (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_wr, .dl_addr, .dl_data,
		.bios_addr, .patch_en, .bios_q
	);

	backup_manager u_backup_manager (
		.clk_sys, .reset, .cart_busy, .autosave, .bk_load_cmd, .bk_save_cmd,
		.osd_status, .bram_addr, .bram_data, .bram_wr, .bram_q,
		.sd_lba, .sd_rd, .sd_wr, .sd_ack, .sd_buff_addr, .sd_buff_dout,
		.sd_buff_wr, .sd_buff_din, .bk_busy, .bk_pending
	);

endmodule

// ==== hw/backup_manager.sv ====
//============================================================
// backup (save) ram manager
// dual port ram shared by the core and the sd sector buffer,
// unsaved-write tracking and the four sector load/save
// sequencer driven by sd_ack edges
//============================================================
`timescale 1ns/1ps

module backup_manager (
	input  logic                                        clk_sys,
	input  logic                                        reset,
	input  logic                                        cart_busy,
	input  logic                                        autosave,
	input  logic                                        bk_load_cmd,
	input  logic                                        bk_save_cmd,
	input  logic                                        osd_status,
	input  logic [media_pkg::BRAM_ADDR_W-1:0]           bram_addr,
	input  logic [15:0]                                 bram_data,
	input  logic                                        bram_wr,
	output logic [15:0]                                 bram_q,
	output logic [$clog2(media_pkg::BK_SECTORS)-1:0]    sd_lba,
	output logic                                        sd_rd,
	output logic                                        sd_wr,
	input  logic                                        sd_ack,
	input  logic [7:0]                                  sd_buff_addr,
	input  logic [15:0]                                 sd_buff_dout,
	input  logic                                        sd_buff_wr,
	output logic [15:0]                                 sd_buff_din,
	output logic                                        bk_busy,
	output logic                                        bk_pending
);
	import media_pkg::*;

	logic [15:0]            bram [0:(2**BRAM_ADDR_W)-1];
	logic [BRAM_ADDR_W-1:0] sd_ram_addr;
	logic                   sd_ram_we;
	bk_state_e              bk_state;
	logic                   bk_ena;       // save file usable
	logic                   bk_loading;   // 1 load, 0 save
	logic                   old_busy;
	logic                   old_ack;
	logic                   old_osd;
	logic                   cart_start;
	logic                   cart_end;
	logic                   auto_save;
	logic                   xfer_start;
	logic                   start_load;

	// ========================================================
	// dual port save ram
	// ========================================================
	assign sd_ram_addr = {sd_lba, sd_buff_addr};
	assign sd_ram_we   = sd_buff_wr && sd_ack;

	always_ff @(posedge clk_sys) begin
		if (bram_wr)
			bram[bram_addr] <= bram_data;    // core port
		bram_q <= bram[bram_addr];
		if (sd_ram_we)
			bram[sd_ram_addr] <= sd_buff_dout;  // sd port
		sd_buff_din <= bram[sd_ram_addr];
	end

	// ========================================================
	// flags and start conditions
	// ========================================================
	assign cart_start = cart_busy && !old_busy;
	assign cart_end   = !cart_busy && old_busy;   // auto load after cart
	assign auto_save  = autosave && bk_pending && osd_status && !old_osd;
	assign xfer_start = (bk_state == BK_IDLE) &&
		(cart_end || (bk_ena && (bk_load_cmd || bk_save_cmd || auto_save)));
	assign start_load = cart_end || bk_load_cmd;  // anything else is a save

	assign bk_busy = (bk_state == BK_XFER);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_busy   <= 1'b0;
			old_osd    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_busy <= cart_busy;
			old_osd  <= osd_status;
			if (cart_start)
				bk_ena <= 1'b0;      // new cart, old save invalid
			else if (cart_end)
				bk_ena <= 1'b1;
			if (xfer_start)
				bk_pending <= 1'b0;
			else if (bk_ena && !osd_status && bram_wr)
				bk_pending <= 1'b1;  // unsaved core write
		end
	end

	// ========================================================
	// sector sequencer
	// ========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_state   <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;           // request taken
				sd_wr <= 1'b0;
			end
			case (bk_state)
				BK_IDLE: begin
					if (xfer_start) begin
						bk_state   <= BK_XFER;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= !start_load;
					end
				end
				BK_XFER: begin
					if (old_ack && !sd_ack) begin   // sector done
						if (sd_lba == $bits(sd_lba)'(BK_SECTORS - 1)) begin
							bk_state <= BK_IDLE;
							sd_lba   <= '0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: bk_state <= BK_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/bios_rom.sv ====
//============================================================
// bios byte rom, filled from the host download
// each 16-bit word is written as two bytes on back to back
// cycles, low byte first. core reads have 1 cycle latency and
// an optional patch over the cart checksum branch
//============================================================
`timescale 1ns/1ps

module bios_rom (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                dl_active,
	input  media_pkg::dl_index_e                dl_index,
	input  logic                                dl_wr,
	input  logic [media_pkg::DL_ADDR_W-1:0]     dl_addr,
	input  logic [15:0]                         dl_data,
	input  logic [media_pkg::BIOS_ADDR_W-1:0]   bios_addr,
	input  logic                                patch_en,
	output logic [7:0]                          bios_q
);
	import media_pkg::*;

	logic [7:0]             rom [0:(2**BIOS_ADDR_W)-1];
	logic                   os_dl;
	logic                   wr_en;
	logic                   byte_sel;     // 0 low byte next, 1 high/idle
	logic [BIOS_ADDR_W-2:0] word_addr;    // latched word address
	logic [15:0]            word_data;
	logic [BIOS_ADDR_W-1:0] ram_addr;
	logic [7:0]             ram_din;
	logic [7:0]             ram_q;
	logic [BIOS_ADDR_W-1:0] rd_addr_q;    // address of the byte in ram_q

	assign os_dl = dl_active && (dl_index == IDX_BIOS || dl_index == IDX_BIOS_ALT);

	// ========================================================
	// split word loader
	// ========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_en    <= 1'b0;
			byte_sel <= 1'b1;
		end else if (os_dl && dl_wr) begin
			wr_en    <= 1'b1;          // low byte next cycle
			byte_sel <= 1'b0;
		end else if (!byte_sel) begin
			wr_en    <= 1'b1;          // then the high byte
			byte_sel <= 1'b1;
		end else begin
			wr_en <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (os_dl && dl_wr) begin
			word_addr <= dl_addr[BIOS_ADDR_W-1:1];
			word_data <= dl_data;
		end
	end

	// write side owns the address while loading
	assign ram_addr = (os_dl || wr_en) ? {word_addr, byte_sel} : bios_addr;
	assign ram_din  = byte_sel ? word_data[15:8] : word_data[7:0];

	// ========================================================
	// byte ram and patched read port
	// ========================================================
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			rom[ram_addr] <= ram_din;
		ram_q     <= rom[ram_addr];
		rd_addr_q <= bios_addr;
	end

	assign bios_q = (patch_en && rd_addr_q == BIOS_PATCH_ADDR) ? BIOS_PATCH_BYTE : ram_q;

endmodule

// ==== hw/cart_loader.sv ====
//============================================================
// cartridge loader
// turns the host 16-bit download into 64-bit external memory
// writes with lane enables, starting at the cart base address
// host is held in wait until each write is acknowledged
//============================================================
`timescale 1ns/1ps

module cart_loader (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                dl_active,
	input  media_pkg::dl_index_e                dl_index,
	input  logic                                dl_wr,
	input  logic [media_pkg::DL_ADDR_W-1:0]     dl_addr,
	input  logic [15:0]                         dl_data,
	output logic [media_pkg::MEM_ADDR_W-1:0]    mem_addr,
	output logic [63:0]                         mem_din,
	output logic [7:0]                          mem_be,
	output logic                                mem_we,
	input  logic                                mem_ack,
	output logic                                dl_wait,
	output logic                                cart_busy
);
	import media_pkg::*;

	logic        cart_dl;       // cart slot download in progress
	logic        old_dl;
	logic [23:0] loader_addr;   // running byte address
	logic [15:0] data_q;        // word held for the write
	logic [15:0] data_bs;

	assign cart_dl = dl_active && (dl_index == IDX_CART);

	// host address not used, words arrive in order
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl      <= 1'b0;
			cart_busy   <= 1'b0;
			mem_we      <= 1'b0;
			dl_wait     <= 1'b0;
			loader_addr <= CART_BASE;
		end else begin
			old_dl <= cart_dl;
			mem_we <= 1'b0;                    // strobe default
			if (!old_dl && cart_dl) begin      // start of download
				loader_addr <= CART_BASE;
				cart_busy   <= 1'b1;
			end
			if (old_dl && !cart_dl)
				cart_busy <= 1'b0;
			if (mem_we)
				loader_addr <= loader_addr + 24'd2;  // one word per write
			if (dl_wr && cart_dl) begin
				mem_we  <= 1'b1;
				dl_wait <= 1'b1;               // back-pressure until ack
			end else if (mem_ack) begin
				dl_wait <= 1'b0;
			end
		end
	end

	// payload, captured with the host strobe
	always_ff @(posedge clk_sys) begin
		if (dl_wr && cart_dl)
			data_q <= dl_data;
	end

	assign data_bs  = {data_q[7:0], data_q[15:8]};   // byte swap
	assign mem_din  = {4{data_bs}};                   // same word on every lane
	assign mem_addr = {MEM_REGION, loader_addr[23:3]};

	// lane enable from the word offset in the 64-bit line
	always_comb begin
		case (loader_addr[2:0])
			3'd0:    mem_be = 8'hC0;
			3'd2:    mem_be = 8'h30;
			3'd4:    mem_be = 8'h0C;
			3'd6:    mem_be = 8'h03;
			default: mem_be = 8'hFF;   // odd offset, not expected
		endcase
	end

endmodule

// ==== hw/media_config.sv ====
//============================================================
// options register block
// host writes options and commands through cfg_wr/cfg_sel
// options persist as levels, commands leave as 1-cycle pulses
//============================================================
`timescale 1ns/1ps

module media_config (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cfg_wr,      // single cycle strobe
	input  media_pkg::cfg_reg_e  cfg_sel,
	input  logic [7:0]           cfg_data,
	output logic                 patch_en,
	output logic                 autosave,
	output logic                 bk_load_cmd,
	output logic                 bk_save_cmd
);
	import media_pkg::*;

	logic [1:0] options;    // {autosave, patch}
	logic       opt_wr;
	logic       cmd_wr;

	assign opt_wr = cfg_wr && (cfg_sel == CFG_OPTIONS);
	assign cmd_wr = cfg_wr && (cfg_sel == CFG_COMMAND);

	assign patch_en = options[0];
	assign autosave = options[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			options     <= 2'b00;
			bk_load_cmd <= 1'b0;
			bk_save_cmd <= 1'b0;
		end else begin
			// command bits never stick, one pulse per write
			bk_load_cmd <= cmd_wr && cfg_data[0];
			bk_save_cmd <= cmd_wr && cfg_data[1];
			if (opt_wr)
				options <= cfg_data[1:0];
		end
	end

endmodule

// ==== hw/media_pkg.sv ====
//============================================================
// shared widths, addresses and encodings for the media
// loading side: cart loader, bios rom, backup ram, options
// every block pulls this in with a wildcard import
//============================================================
package media_pkg;

	// ========================================================
	// widths and addresses
	// ========================================================
	localparam int DL_ADDR_W   = 25;           // host download byte address
	localparam int MEM_ADDR_W  = 28;           // external memory word address
	localparam int BIOS_ADDR_W = 17;           // 128k byte bios
	localparam int BRAM_ADDR_W = 10;           // save ram, 16-bit words
	localparam int BK_SECTORS  = 4;            // sectors per backup transfer

	localparam logic [23:0] CART_BASE  = 24'h80_0000; // cart rom byte address
	localparam logic [6:0]  MEM_REGION = 7'b0110000;  // upper ext memory bits

	// checksum branch patch, beq turned into bra
	localparam logic [BIOS_ADDR_W-1:0] BIOS_PATCH_ADDR = 17'h0136E;
	localparam logic [7:0]             BIOS_PATCH_BYTE = 8'h60;

	// ========================================================
	// encodings
	// ========================================================
	// download slot from the host menu
	typedef enum logic [5:0] {
		IDX_BIOS     = 6'd0,
		IDX_CART     = 6'd1,
		IDX_BIOS_ALT = 6'd2
	} dl_index_e;

	// option register select
	typedef enum logic [0:0] {
		CFG_OPTIONS = 1'b0,   // bit0 patch enable, bit1 autosave
		CFG_COMMAND = 1'b1    // bit0 backup load, bit1 backup save
	} cfg_reg_e;

	// backup sequencer
	typedef enum logic [0:0] {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_e;

endpackage
